//--- ctrl_arb_settings.svh
// Build-time constants for the control request concentrator
// Requester count, FIFO depths and programmable-full levels

`ifndef CTRL_ARB_SETTINGS_SVH
`define CTRL_ARB_SETTINGS_SVH

// ------------------------------
// Requester side
// ------------------------------
// Number of requesters feeding the arbiter
`define CTRL_NUM_REQUESTORS 4
// Source id width, must cover the requester count
`define CTRL_ID_BITS 2

// ------------------------------
// FIFO sizing
// ------------------------------
// One ingress FIFO per requester
`define CTRL_IN_FIFO_DEPTH 16
`define CTRL_IN_PROG_THRESH 12
// Shared egress FIFO, leaves room for packets still in flight
`define CTRL_OUT_FIFO_DEPTH 8
`define CTRL_OUT_PROG_THRESH 4

`endif

//--- ctrl_arb_pkg.sv
// Shared types for the control request concentrator
// Requester id, payload, packet and FIFO status structs

`include "ctrl_arb_settings.svh"

package ctrl_arb_pkg;

  // ------------------------------
  // Packet types
  // ------------------------------
  // Index of one requester
  typedef logic [`CTRL_ID_BITS-1:0] requester_id_t;

  // Body of a control request, 42 bits
  typedef struct packed {
    // Requester that issued the packet
    requester_id_t source_id;
    // Per-requester running count
    logic [7:0]    sequence_num;
    // Control word for the overlay
    logic [31:0]   data;
  } control_payload_t;

  // Payload plus its qualifier
  typedef struct packed {
    logic             valid;
    control_payload_t payload;
  } control_packet_t;

  // ------------------------------
  // FIFO flags
  // ------------------------------
  typedef struct packed {
    logic empty;
    logic full;
    // Occupancy at or above the threshold
    logic prog_full;
  } fifo_status_t;

endpackage : ctrl_arb_pkg

//--- ctrl_sync_fifo.sv
// Behavioural synchronous FIFO for control payloads
// Registered read data with valid, empty/full/prog_full flags

module ctrl_sync_fifo
  import ctrl_arb_pkg::*;
#(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  control_payload_t din,
  input  logic             wr_en,
  input  logic             rd_en,
  output control_payload_t dout,
  output logic             valid,
  output fifo_status_t     status
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  localparam logic [PTR_BITS-1:0] LAST_PTR   = PTR_BITS'(DEPTH - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT   = CNT_BITS'(DEPTH);
  localparam logic [CNT_BITS-1:0] THRESH_CNT = CNT_BITS'(PROG_THRESH);

  // ------------------------------
  // Storage and pointers
  // ------------------------------
  control_payload_t    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  logic do_write;
  logic do_read;

  // Drop writes when full, ignore reads when empty
  assign do_write = wr_en & ~status.full;
  assign do_read  = rd_en & ~status.empty;

  // Flags straight from the occupancy count
  assign status.empty     = (count == '0);
  assign status.full      = (count == FULL_CNT);
  assign status.prog_full = (count >= THRESH_CNT);

  // Pointer and count bookkeeping
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Net occupancy change
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------
  // Data path
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
    if (do_read) begin
      dout <= mem[rd_ptr];
    end
  end

  // Read qualifier, one cycle after the pop
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      valid <= 1'b0;
    end else begin
      valid <= do_read;
    end
  end

endmodule : ctrl_sync_fifo

//--- ctrl_ingress_buffers.sv
// First stage of the concentrator
// Requester input registers, one FIFO per requester, ready flags

`include "ctrl_arb_settings.svh"

module ctrl_ingress_buffers
  import ctrl_arb_pkg::*;
(
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  control_packet_t                   request_in     [`CTRL_NUM_REQUESTORS-1:0],
  input  logic [`CTRL_NUM_REQUESTORS-1:0]   grant,
  input  logic                              egress_prog_full,
  output control_packet_t                   ingress_head   [`CTRL_NUM_REQUESTORS-1:0],
  output fifo_status_t                      ingress_status [`CTRL_NUM_REQUESTORS-1:0],
  output logic [`CTRL_NUM_REQUESTORS-1:0]   request_ready
);

  localparam int N = `CTRL_NUM_REQUESTORS;

  control_packet_t  request_in_reg [N-1:0];
  control_payload_t fifo_dout      [N-1:0];
  logic [N-1:0]     fifo_valid;
  logic [N-1:0]     fifo_rd_en;

  // ------------------------------
  // Input registers
  // ------------------------------
  // Only the qualifier is cleared
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      for (int i = 0; i < N; i++) begin
        request_in_reg[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        request_in_reg[i].valid <= request_in[i].valid;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < N; i++) begin
      request_in_reg[i].payload <= request_in[i].payload;
    end
  end

  // ------------------------------
  // Per-requester FIFOs
  // ------------------------------
  for (genvar i = 0; i < N; i++) begin : gen_ingress_fifo
    // Pop only a granted FIFO that holds data
    assign fifo_rd_en[i]   = grant[i] & ~ingress_status[i].empty;
    // Head seen by the arbiter
    assign ingress_head[i] = '{valid: fifo_valid[i], payload: fifo_dout[i]};

    ctrl_sync_fifo #(
      .DEPTH      (`CTRL_IN_FIFO_DEPTH),
      .PROG_THRESH(`CTRL_IN_PROG_THRESH)
    ) u_ingress_fifo (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .din           (request_in_reg[i].payload),
      .wr_en         (request_in_reg[i].valid),
      .rd_en         (fifo_rd_en[i]),
      .dout          (fifo_dout[i]),
      .valid         (fifo_valid[i]),
      .status        (ingress_status[i])
    );
  end

  // Ready drops on own backlog or on shared egress backlog
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_ready <= '1;
    end else begin
      for (int i = 0; i < N; i++) begin
        request_ready[i] <= ~ingress_status[i].prog_full & ~egress_prog_full;
      end
    end
  end

endmodule : ctrl_ingress_buffers

//--- ctrl_rr_arbiter.sv
// Second stage of the concentrator
// Round-robin grant over non-empty ingress FIFOs, registered bus mux

`include "ctrl_arb_settings.svh"

module ctrl_rr_arbiter
  import ctrl_arb_pkg::*;
(
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  control_packet_t                 ingress_head   [`CTRL_NUM_REQUESTORS-1:0],
  input  fifo_status_t                    ingress_status [`CTRL_NUM_REQUESTORS-1:0],
  input  logic                            egress_prog_full,
  output logic [`CTRL_NUM_REQUESTORS-1:0] grant,
  output control_packet_t                 arb_packet
);

  localparam int N = `CTRL_NUM_REQUESTORS;

  requester_id_t last_ptr;
  requester_id_t grant_idx;
  requester_id_t grant_idx_d;
  logic          grant_any;
  logic          grant_d;

  // ------------------------------
  // Grant search
  // ------------------------------
  // Start one past the last winner and wrap
  always_comb begin
    int j;
    grant     = '0;
    grant_idx = last_ptr;
    grant_any = 1'b0;
    for (int k = 1; k <= N; k++) begin
      j = (int'(last_ptr) + k) % N;
      // Hold off while egress has no spare room
      if (!grant_any && !ingress_status[j].empty && !egress_prog_full) begin
        grant[j]  = 1'b1;
        grant_idx = requester_id_t'(j);
        grant_any = 1'b1;
      end
    end
  end

  // Last winner, reset so requester 0 goes first
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      last_ptr <= requester_id_t'(N - 1);
      grant_d  <= 1'b0;
    end else begin
      if (grant_any) begin
        last_ptr <= grant_idx;
      end
      grant_d <= grant_any;
    end
  end

  // Winner index for the read data one cycle later
  always_ff @(posedge ap_clk) begin
    grant_idx_d <= grant_idx;
  end

  // ------------------------------
  // Bus mux
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arb_packet.valid <= 1'b0;
    end else begin
      arb_packet.valid <= grant_d & ingress_head[grant_idx_d].valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    arb_packet.payload <= ingress_head[grant_idx_d].payload;
  end

endmodule : ctrl_rr_arbiter

//--- ctrl_egress_queue.sv
// Third stage of the concentrator
// Arbiter output register, egress FIFO, registered output and status

`include "ctrl_arb_settings.svh"

module ctrl_egress_queue
  import ctrl_arb_pkg::*;
(
  input  logic            ap_clk,
  input  logic            areset_control,
  input  control_packet_t arb_packet,
  input  logic            pop,
  output control_packet_t request_out,
  output fifo_status_t    egress_status,
  output logic            egress_prog_full
);

  control_packet_t  arb_packet_reg;
  control_payload_t fifo_dout;
  logic             fifo_valid;
  logic             fifo_rd_en;
  fifo_status_t     fifo_status;

  // ------------------------------
  // Input register
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arb_packet_reg.valid <= 1'b0;
    end else begin
      arb_packet_reg.valid <= arb_packet.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    arb_packet_reg.payload <= arb_packet.payload;
  end

  // Pop on empty is ignored
  assign fifo_rd_en = pop & ~fifo_status.empty;
  // Unregistered, the arbiter needs it early
  assign egress_prog_full = fifo_status.prog_full;

  ctrl_sync_fifo #(
    .DEPTH      (`CTRL_OUT_FIFO_DEPTH),
    .PROG_THRESH(`CTRL_OUT_PROG_THRESH)
  ) u_egress_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (arb_packet_reg.payload),
    .wr_en         (arb_packet_reg.valid),
    .rd_en         (fifo_rd_en),
    .dout          (fifo_dout),
    .valid         (fifo_valid),
    .status        (fifo_status)
  );

  // ------------------------------
  // Output registers
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_out.valid <= 1'b0;
      egress_status     <= '{empty: 1'b1, full: 1'b0, prog_full: 1'b0};
    end else begin
      request_out.valid <= fifo_valid;
      egress_status     <= fifo_status;
    end
  end

  always_ff @(posedge ap_clk) begin
    request_out.payload <= fifo_dout;
  end

endmodule : ctrl_egress_queue

//--- ctrl_request_arbiter.sv
// Top level of the many-to-one control request concentrator
// Reset register and the ingress, arbiter and egress stages

`include "ctrl_arb_settings.svh"

module ctrl_request_arbiter
  import ctrl_arb_pkg::*;
(
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  control_packet_t                 request_in [`CTRL_NUM_REQUESTORS-1:0],
  input  logic                            pop,
  output control_packet_t                 request_out,
  output logic [`CTRL_NUM_REQUESTORS-1:0] request_ready,
  output fifo_status_t                    egress_status
);

  localparam int N = `CTRL_NUM_REQUESTORS;

  // ------------------------------
  // Stage links
  // ------------------------------
  logic            areset_reg;
  control_packet_t ingress_head   [N-1:0];
  fifo_status_t    ingress_status [N-1:0];
  logic [N-1:0]    grant;
  control_packet_t arb_packet;
  logic            egress_prog_full;

  // One registered reset copy for every stage
  always_ff @(posedge ap_clk) begin
    areset_reg <= areset_control;
  end

  ctrl_ingress_buffers u_ingress (
    .ap_clk          (ap_clk),
    .areset_control  (areset_reg),
    .request_in      (request_in),
    .grant           (grant),
    .egress_prog_full(egress_prog_full),
    .ingress_head    (ingress_head),
    .ingress_status  (ingress_status),
    .request_ready   (request_ready)
  );

  ctrl_rr_arbiter u_arbiter (
    .ap_clk          (ap_clk),
    .areset_control  (areset_reg),
    .ingress_head    (ingress_head),
    .ingress_status  (ingress_status),
    .egress_prog_full(egress_prog_full),
    .grant           (grant),
    .arb_packet      (arb_packet)
  );

  // Downstream side
  ctrl_egress_queue u_egress (
    .ap_clk          (ap_clk),
    .areset_control  (areset_reg),
    .arb_packet      (arb_packet),
    .pop             (pop),
    .request_out     (request_out),
    .egress_status   (egress_status),
    .egress_prog_full(egress_prog_full)
  );

endmodule : ctrl_request_arbiter

//--- ctrl_request_arbiter_tb.sv
// Self-checking testbench for the control request concentrator
// Pattern-file traffic with reset, round-robin, back-pressure and drain checks

`include "ctrl_arb_settings.svh"

module ctrl_request_arbiter_tb
  import ctrl_arb_pkg::*;
();

  localparam int N         = `CTRL_NUM_REQUESTORS;
  localparam int PAT_WORDS = 60;
  // Counts row and order row come before the data words
  localparam int DATA_BASE = 2 * N;
  localparam fifo_status_t EMPTY_STATUS = '{empty: 1'b1, full: 1'b0, prog_full: 1'b0};

  logic            ap_clk;
  logic            areset_control;
  control_packet_t request_in [N-1:0];
  logic            pop;
  control_packet_t request_out;
  logic [N-1:0]    request_ready;
  fifo_status_t    egress_status;

  // ------------------------------
  // Scoreboard state
  // ------------------------------
  logic [31:0]     patterns [PAT_WORDS];
  int              pkt_count [N];
  int              data_start [N];
  int              sent_cnt [N];
  int              rx_cnt [N];
  int              rx_total;
  int              total_pkts;
  logic [31:0]     rng_state;
  control_packet_t rx_log [$];

  ctrl_request_arbiter u_ctrl_request_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request_in    (request_in),
    .pop           (pop),
    .request_out   (request_out),
    .request_ready (request_ready),
    .egress_status (egress_status)
  );

  initial ap_clk = 1'b0;
  always #5 ap_clk = ~ap_clk;

  // Packet k of one requester, as listed in the pattern file
  function automatic control_packet_t make_packet(input int req, input int k);
    control_packet_t pkt;
    pkt.valid                = 1'b1;
    pkt.payload.source_id    = requester_id_t'(req);
    pkt.payload.sequence_num = 8'(k);
    pkt.payload.data         = patterns[data_start[req] + k];
    return pkt;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic coin_flip();
    rng_state = lcg_next(rng_state);
    return rng_state[16];
  endfunction

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "Stopping at the first error");
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  // Payload is a don't-care on an idle bus
  task automatic check_packet(input string name, input control_packet_t got,
                              input control_packet_t exp);
    if (got.valid !== exp.valid || (exp.valid && got.payload !== exp.payload)) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_status(input string name, input fifo_status_t got,
                              input fifo_status_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_ready(input string name, input logic [N-1:0] got,
                             input logic [N-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // Per-source ordering, each packet once
  task automatic take_output();
    int id;
    if (request_out.valid === 1'b1) begin
      if ($isunknown(request_out.payload.source_id)) begin
        $display("Output packet carries an unknown source id");
        stop_on_error();
      end
      id = int'(request_out.payload.source_id);
      if (rx_cnt[id] >= sent_cnt[id]) begin
        $display("Requester %0d delivered a packet that was never sent", id);
        stop_on_error();
      end
      check_packet("request_out", request_out, make_packet(id, rx_cnt[id]));
      rx_log.push_back(request_out);
      rx_cnt[id]++;
      rx_total++;
    end
  endtask

  // Outputs are sampled and inputs driven on the falling edge
  task automatic tick();
    @(negedge ap_clk);
    take_output();
  endtask

  task automatic idle_requests();
    for (int i = 0; i < N; i++) begin
      request_in[i].valid = 1'b0;
    end
  endtask

  // Ready-gated traffic, optionally thinned by the LCG
  task automatic drive_requests(input logic random_gate);
    for (int i = 0; i < N; i++) begin
      request_in[i].valid = 1'b0;
      if (request_ready[i] && sent_cnt[i] < pkt_count[i]) begin
        if (!random_gate || coin_flip()) begin
          request_in[i] = make_packet(i, sent_cnt[i]);
          sent_cnt[i]++;
        end
      end
    end
  endtask

  initial begin
    int cycles;
    areset_control = 1'b1;
    pop            = 1'b0;
    rx_total       = 0;
    total_pkts     = 0;
    rng_state      = 32'd98166;
    for (int i = 0; i < N; i++) begin
      request_in[i] = '0;
      sent_cnt[i]   = 0;
      rx_cnt[i]     = 0;
    end
    $readmemh("ctrl_request_arbiter_patterns.hex", patterns);
    for (int i = 0; i < N; i++) begin
      pkt_count[i]  = int'(patterns[i]);
      data_start[i] = DATA_BASE + total_pkts;
      total_pkts   += pkt_count[i];
    end
    if (DATA_BASE + total_pkts > PAT_WORDS) begin
      $display("Pattern file lists more packets than it holds data words");
      stop_on_error();
    end

    // ------------------------------
    // Reset values
    // ------------------------------
    repeat (8) @(negedge ap_clk);
    areset_control = 1'b0;
    tick();
    check_packet("request_out", request_out, '0);
    check_ready("request_ready", request_ready, '1);
    check_status("egress_status", egress_status, EMPTY_STATUS);

    // Round robin: one packet per requester in the same cycle
    drive_requests(1'b0);
    tick();
    idle_requests();
    cycles = 0;
    while (egress_status.prog_full !== 1'b1) begin
      tick();
      cycles++;
      if (cycles > 50) begin
        $display("Egress FIFO never reached its threshold with four queued packets");
        stop_on_error();
      end
    end
    pop    = 1'b1;
    cycles = 0;
    while (rx_total < N) begin
      tick();
      cycles++;
      if (cycles > 50) begin
        $display("The four round-robin packets did not all come out");
        stop_on_error();
      end
    end
    pop = 1'b0;
    // Expected source order comes from the second pattern row
    for (int k = 0; k < N; k++) begin
      check_packet("request_out", rx_log[k], make_packet(int'(patterns[N + k]), 0));
    end

    // ------------------------------
    // Back-pressure with pop held low
    // ------------------------------
    cycles = 0;
    while (egress_status.prog_full !== 1'b1) begin
      drive_requests(1'b0);
      tick();
      cycles++;
      if (cycles > 100) begin
        $display("Egress FIFO never reached its threshold under back-pressure");
        stop_on_error();
      end
    end
    // Both flags come from the same egress count register stage
    check_ready("request_ready", request_ready, '0);
    idle_requests();
    repeat (10) begin
      drive_requests(1'b0);
      tick();
      check_ready("request_ready", request_ready, '0);
    end

    // Random pop and random traffic until every packet is out
    cycles = 0;
    while (rx_total < total_pkts) begin
      pop = coin_flip();
      drive_requests(1'b1);
      tick();
      cycles++;
      if (cycles > 3000) begin
        $display("Not all pattern packets came out of the concentrator");
        stop_on_error();
      end
    end
    idle_requests();

    // Quiet window catches duplicate packets
    pop = 1'b1;
    repeat (20) tick();
    pop = 1'b0;
    tick();
    check_status("egress_status", egress_status, EMPTY_STATUS);
    check_ready("request_ready", request_ready, '1);

    $display("sim passed");
    $finish;
  end

endmodule : ctrl_request_arbiter_tb

//--- ctrl_request_arbiter_patterns.hex
// Row 1: packet count of requesters 0..3; row 2: expected round-robin source order
// Remaining rows: 32-bit data words of requester 0, 1, 2, 3 in sequence order
0000000e 0000000c 0000000d 0000000d
00000000 00000001 00000002 00000003
// Requester 0
a0000001 a1234567 a2b4c6d8 a3000010 a4ffee01 a5a5a5a5 a6010203
a7deadb0 a8c0ffee a9000a0b aa5a5a5a ab13579b ac2468ac ad0f0f0f
// Requester 1
b0000002 b1fedcba b2112233 b3445566 b4778899 b5aabbcc
b6ddeeff b7000077 b8f0f0f0 b9876543 ba0c0c0c bb314159
// Requester 2
c0000003 c1abcdef c2102030 c3405060 c4708090 c5a0b0c0 c6d0e0f0
c7111111 c8222222 c9333333 ca444444 cb555555 cc666666
// Requester 3
d0000004 d1cafe00 d2beef11 d3f00d22 d4babe33 d5face44 d6dead55
d7c0de66 d8bead77 d9ace088 da0bad99 db1234aa dc5678bb

//--- ctrl_request_arbiter.f
+incdir+.
ctrl_arb_pkg.sv
ctrl_sync_fifo.sv
ctrl_ingress_buffers.sv
ctrl_rr_arbiter.sv
ctrl_egress_queue.sv
ctrl_request_arbiter.sv
ctrl_request_arbiter_tb.sv

//--- Bender.yml
package:
  name: ctrl_request_arbiter

sources:
  - include_dirs:
      - .
    files:
      - ctrl_arb_pkg.sv
      - ctrl_sync_fifo.sv
      - ctrl_ingress_buffers.sv
      - ctrl_rr_arbiter.sv
      - ctrl_egress_queue.sv
      - ctrl_request_arbiter.sv
  - target: test
    include_dirs:
      - .
    files:
      - ctrl_request_arbiter_tb.sv
